/* exe_pkg.sv */
// Execute stage definitions
package exe_pkg;

    typedef logic [31:0] data_t;         // Operands, results and addresses
    typedef logic [4:0]  reg_addr_t;     // Register file index
    typedef logic [4:0]  alu_op_t;       // Bit 4 set selects the M extension
    typedef logic [1:0]  store_op_t;
    typedef logic [2:0]  load_op_t;      // Passed through to memory stage
    typedef logic [3:0]  be_t;
    typedef logic [1:0]  data_origin_t;  // Bit 0 imm as op 2, bit 1 link is pc+4
    typedef logic [1:0]  data_target_t;  // Writeback value select

    // Base ALU operations, bit 4 clear
    localparam alu_op_t ALU_ADD  = 5'b0_0000;
    localparam alu_op_t ALU_SUB  = 5'b0_0001;
    localparam alu_op_t ALU_SLL  = 5'b0_0010;
    localparam alu_op_t ALU_SLT  = 5'b0_0011;
    localparam alu_op_t ALU_SLTU = 5'b0_0100;
    localparam alu_op_t ALU_XOR  = 5'b0_0101;
    localparam alu_op_t ALU_SRL  = 5'b0_0110;
    localparam alu_op_t ALU_SRA  = 5'b0_0111;
    localparam alu_op_t ALU_OR   = 5'b0_1000;
    localparam alu_op_t ALU_AND  = 5'b0_1001;
    localparam alu_op_t ALU_LUI  = 5'b0_1010;  // Passes operand 2

    // M extension, low three bits are funct3
    localparam alu_op_t MUL    = 5'b1_0000;
    localparam alu_op_t MULH   = 5'b1_0001;
    localparam alu_op_t MULHSU = 5'b1_0010;
    localparam alu_op_t MULHU  = 5'b1_0011;
    localparam alu_op_t DIV    = 5'b1_0100;
    localparam alu_op_t DIVU   = 5'b1_0101;
    localparam alu_op_t REM    = 5'b1_0110;
    localparam alu_op_t REMU   = 5'b1_0111;

    // Store widths, the fourth code gives zero data
    localparam store_op_t STORE_SB = 2'b00;
    localparam store_op_t STORE_SH = 2'b01;
    localparam store_op_t STORE_SW = 2'b10;

    typedef enum logic [1:0] {
        MD_IDLE,
        MD_RUN,
        MD_DONE
    } md_state_t;

    // One iteration per operand bit
    localparam int MD_CYCLES = 32;

endpackage

/* muldiv_if.sv */
// Multiply and divide bus
interface muldiv_if;
    import exe_pkg::*;

    data_t      op_a;
    data_t      op_b;
    logic [2:0] funct;   // funct3 of the M instruction
    logic       start;   // Sampled only while the unit is idle
    data_t      result;  // Held until the next start
    logic       busy;

    modport requester (
        output op_a,
        output op_b,
        output funct,
        output start,
        input  result,
        input  busy
    );

    modport unit (
        input  op_a,
        input  op_b,
        input  funct,
        input  start,
        output result,
        output busy
    );

endinterface

/* int_alu.sv */
// RV32I integer ALU
module int_alu (
    input  exe_pkg::alu_op_t alu_op_i,
    input  exe_pkg::data_t   op_a_i,
    input  exe_pkg::data_t   op_b_i,
    output exe_pkg::data_t   result_o
);
    import exe_pkg::*;

    alu_op_t    base_op;
    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // Only the low four bits name a base operation
    assign base_op = {1'b0, alu_op_i[3:0]};
    assign shamt   = op_b_i[4:0];

    assign lt_signed   = $signed(op_a_i) < $signed(op_b_i);
    assign lt_unsigned = op_a_i < op_b_i;

    always_comb
    begin
        case (base_op)
            ALU_ADD:
                result_o = op_a_i + op_b_i;
            ALU_SUB:
                result_o = op_a_i - op_b_i;
            ALU_SLL:
                result_o = op_a_i << shamt;
            ALU_SLT:
                result_o = {31'b0, lt_signed};
            ALU_SLTU:
                result_o = {31'b0, lt_unsigned};
            ALU_XOR:
                result_o = op_a_i ^ op_b_i;
            ALU_SRL:
                result_o = op_a_i >> shamt;
            ALU_SRA:
                result_o = data_t'($signed(op_a_i) >>> shamt);  // Sign fill
            ALU_OR:
                result_o = op_a_i | op_b_i;
            ALU_AND:
                result_o = op_a_i & op_b_i;
            ALU_LUI:
                result_o = op_b_i;  // Immediate already shifted by decode
            default:
                result_o = '0;
        endcase
    end

endmodule

/* muldiv_unit.sv */
// Iterative RV32M unit
module muldiv_unit (
    input logic    clk,
    input logic    rst_n,
    muldiv_if.unit md
);
    import exe_pkg::*;

    localparam int CNT_W = $clog2(MD_CYCLES);

    md_state_t        state_q;
    logic [CNT_W-1:0] cnt_q;
    data_t            res_q;
    logic [2:0]       funct_q;
    data_t            a_q;         // Raw dividend for divide by zero
    data_t            b_q;         // Magnitude of operand b
    data_t            hi_q;        // Product high half or partial remainder
    data_t            lo_q;        // Multiplier bits, then quotient bits
    logic             neg_q;       // Product or quotient is negative
    logic             neg_rem_q;
    logic             div_zero_q;
    logic             div_ovf_q;

    logic        a_signed;
    logic        b_signed;
    logic        neg_a;
    logic        neg_b;
    data_t       mag_a;
    data_t       mag_b;
    logic [32:0] mul_sum;
    logic [32:0] div_shift;
    logic [32:0] div_diff;
    data_t       hi_n;
    data_t       lo_n;
    logic [63:0] prod;
    data_t       quot;
    data_t       rem;
    data_t       fin;
    logic        last;

    assign a_signed = (md.funct == MULH[2:0]) || (md.funct == MULHSU[2:0])
                   || (md.funct == DIV[2:0]) || (md.funct == REM[2:0]);
    assign b_signed = (md.funct == MULH[2:0]) || (md.funct == DIV[2:0])
                   || (md.funct == REM[2:0]);

    assign neg_a = a_signed & md.op_a[31];
    assign neg_b = b_signed & md.op_b[31];
    assign mag_a = neg_a ? -md.op_a : md.op_a;
    assign mag_b = neg_b ? -md.op_b : md.op_b;

    // One shift-add or restore step per cycle
    assign mul_sum   = {1'b0, hi_q} + (lo_q[0] ? {1'b0, b_q} : 33'd0);
    assign div_shift = {hi_q, lo_q[31]};
    assign div_diff  = div_shift - {1'b0, b_q};

    always_comb
    begin
        if (funct_q[2])
        begin
            hi_n = div_diff[32] ? div_shift[31:0] : div_diff[31:0];
            lo_n = {lo_q[30:0], ~div_diff[32]};
        end
        else
        begin
            hi_n = mul_sum[32:1];
            lo_n = {mul_sum[0], lo_q[31:1]};
        end
    end

    // Sign fix-up and RISC-V corner cases on the final step
    assign prod = neg_q ? -{hi_n, lo_n} : {hi_n, lo_n};
    assign quot = neg_q ? -lo_n : lo_n;
    assign rem  = neg_rem_q ? -hi_n : hi_n;

    always_comb
    begin
        if (!funct_q[2])
            fin = (funct_q == MUL[2:0]) ? prod[31:0] : prod[63:32];
        else if (div_zero_q)
            fin = funct_q[1] ? a_q : '1;
        else if (div_ovf_q)
            fin = funct_q[1] ? '0 : a_q;  // Most negative over -1
        else
            fin = funct_q[1] ? rem : quot;
    end

    assign last = (cnt_q == CNT_W'(MD_CYCLES - 1));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q <= MD_IDLE;
            cnt_q   <= '0;
            res_q   <= '0;
        end
        else
        begin
            case (state_q)
                MD_IDLE:
                begin
                    cnt_q <= '0;
                    if (md.start)
                        state_q <= MD_RUN;
                end
                MD_RUN:
                begin
                    cnt_q <= cnt_q + 1'b1;
                    if (last)
                    begin
                        state_q <= MD_DONE;
                        res_q   <= fin;
                    end
                end
                default:
                    state_q <= MD_IDLE;  // Done lasts a single cycle
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state_q == MD_IDLE && md.start)
        begin
            funct_q    <= md.funct;
            a_q        <= md.op_a;
            b_q        <= mag_b;
            hi_q       <= '0;
            lo_q       <= mag_a;
            neg_q      <= neg_a ^ neg_b;
            neg_rem_q  <= neg_a;
            div_zero_q <= (md.op_b == '0);
            div_ovf_q  <= b_signed & (md.op_a == 32'h8000_0000) & (&md.op_b);
        end
        else if (state_q == MD_RUN)
        begin
            hi_q <= hi_n;
            lo_q <= lo_n;
        end
    end

    assign md.result = res_q;
    assign md.busy   = (state_q == MD_RUN);

endmodule

/* exe_stage.sv */
// Pipeline execute stage
module exe_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  exe_pkg::alu_op_t      e_alu_op_i,
    input  exe_pkg::store_op_t    e_store_op_i,
    input  exe_pkg::load_op_t     e_load_op_i,
    input  exe_pkg::data_origin_t e_data_origin_i,
    input  exe_pkg::data_target_t e_data_target_i,
    input  exe_pkg::data_t        e_rs1_i,
    input  exe_pkg::data_t        e_rs2_i,
    input  exe_pkg::data_t        e_imm_i,
    input  exe_pkg::data_t        e_pc4_i,
    input  exe_pkg::data_t        e_brj_pc_i,
    input  exe_pkg::reg_addr_t    e_waddr_i,
    input  logic                  e_regfile_wr_i,
    input  logic                  e_is_load_store_i,
    input  logic                  e_data_wr_i,
    input  logic                  e_data_rd_i,
    input  exe_pkg::be_t          e_data_be_i,
    input  logic                  stall_general_i,
    output exe_pkg::reg_addr_t    m_waddr_o,
    output exe_pkg::data_t        m_rd_o,
    output exe_pkg::data_t        m_data_addr_o,
    output exe_pkg::data_t        alu_o,
    output logic                  m_regfile_wr_o,
    output logic                  m_is_load_store_o,
    output logic                  m_data_wr_o,
    output logic                  m_data_rd_o,
    output exe_pkg::be_t          m_data_be_o,
    output exe_pkg::load_op_t     m_load_op_o,
    output logic                  d_alu_busy_o
);
    import exe_pkg::*;

    data_t op_b;
    data_t alu_i_res;   // Base ALU result
    data_t store_data;
    data_t rd_val;
    logic  finish_q;    // Busy seen last cycle

    muldiv_if md_bus ();

    assign op_b = e_data_origin_i[0] ? e_imm_i : e_rs2_i;

    int_alu u_int_alu (
        .alu_op_i (e_alu_op_i),
        .op_a_i   (e_rs1_i),
        .op_b_i   (op_b),
        .result_o (alu_i_res)
    );

    // Blocks a restart of a held M instruction once busy has dropped
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            finish_q <= 1'b0;
        else
            finish_q <= md_bus.busy;
    end

    assign md_bus.op_a  = e_rs1_i;
    assign md_bus.op_b  = op_b;
    assign md_bus.funct = e_alu_op_i[2:0];
    assign md_bus.start = e_alu_op_i[4] & ~finish_q;

    muldiv_unit u_muldiv_unit (
        .clk   (clk),
        .rst_n (rst_n),
        .md    (md_bus)
    );

    assign d_alu_busy_o = md_bus.busy;
    assign alu_o        = e_alu_op_i[4] ? md_bus.result : alu_i_res;

    always_comb
    begin
        case (e_store_op_i)
            STORE_SB: store_data = {24'b0, e_rs2_i[7:0]};
            STORE_SH: store_data = {16'b0, e_rs2_i[15:0]};
            STORE_SW: store_data = e_rs2_i;
            default:  store_data = '0;
        endcase
    end

    always_comb
    begin
        case (e_data_target_i)
            2'd0:    rd_val = alu_o;
            2'd1:    rd_val = store_data;
            2'd2:    rd_val = '0;
            default: rd_val = e_data_origin_i[1] ? e_pc4_i : e_brj_pc_i;  // Link address
        endcase
    end

    // Memory stage register, holds while stalled
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            m_waddr_o         <= '0;
            m_rd_o            <= '0;
            m_data_addr_o     <= '0;
            m_regfile_wr_o    <= 1'b0;
            m_is_load_store_o <= 1'b0;
            m_data_wr_o       <= 1'b0;
            m_data_rd_o       <= 1'b0;
            m_data_be_o       <= '0;
            m_load_op_o       <= '0;
        end
        else if (!stall_general_i)
        begin
            m_waddr_o         <= e_waddr_i;
            m_rd_o            <= rd_val;
            m_data_addr_o     <= alu_o;  // Base plus offset for loads and stores
            m_regfile_wr_o    <= e_regfile_wr_i;
            m_is_load_store_o <= e_is_load_store_i;
            m_data_wr_o       <= e_data_wr_i;
            m_data_rd_o       <= e_data_rd_i;
            m_data_be_o       <= e_data_be_i;
            m_load_op_o       <= e_load_op_i;
        end
    end

endmodule

/* tb_exe_ref.svh */
// Execute stage reference model
`ifndef TB_EXE_REF_SVH
`define TB_EXE_REF_SVH

function automatic data_t xorshift32(input data_t x);
    data_t s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

// RV32I register and immediate operations
function automatic data_t ref_alu(input alu_op_t op, input data_t a, input data_t b);
    data_t r;
    case (op)
        ALU_ADD:  r = a + b;
        ALU_SUB:  r = a + ~b + 32'd1;
        ALU_SLL:  r = a << b[4:0];
        ALU_SLT:  r = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
        ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
        ALU_XOR:  r = a ^ b;
        ALU_SRL:  r = a >> b[4:0];
        ALU_SRA:  r = (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'd0);
        ALU_OR:   r = a | b;
        ALU_AND:  r = a & b;
        ALU_LUI:  r = b;
        default:  r = '0;
    endcase
    return r;
endfunction

// RV32M results with the divide by zero and overflow rules
function automatic data_t ref_muldiv(input alu_op_t op, input data_t a, input data_t b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] ua;
    logic signed [63:0] ub;
    int                 qa;
    int                 qb;
    logic               ovf;
    data_t              r;
    sa  = {{32{a[31]}}, a};
    sb  = {{32{b[31]}}, b};
    ua  = {32'd0, a};
    ub  = {32'd0, b};
    qa  = a;
    qb  = b;
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (op)
        MUL:     r = 32'(sa * sb);
        MULH:    r = 32'((sa * sb) >> 32);
        MULHSU:  r = 32'((sa * ub) >> 32);
        MULHU:   r = 32'((ua * ub) >> 32);
        DIV:     r = (b == 0) ? 32'hffff_ffff : (ovf ? a : data_t'(qa / qb));
        DIVU:    r = (b == 0) ? 32'hffff_ffff : a / b;
        REM:     r = (b == 0) ? a : (ovf ? 32'd0 : data_t'(qa % qb));
        default: r = (b == 0) ? a : a % b;  // REMU
    endcase
    return r;
endfunction

function automatic data_t ref_store(input store_op_t sop, input data_t rs2);
    case (sop)
        STORE_SB: return rs2 & 32'h0000_00ff;
        STORE_SH: return rs2 & 32'h0000_ffff;
        STORE_SW: return rs2;
        default:  return 32'd0;
    endcase
endfunction

function automatic data_t ref_writeback(input data_target_t tgt, input data_origin_t org,
                                        input data_t alu, input data_t st,
                                        input data_t pc4, input data_t brj);
    case (tgt)
        2'd0:    return alu;
        2'd1:    return st;
        2'd2:    return 32'd0;
        default: return org[1] ? pc4 : brj;  // Link address
    endcase
endfunction

`endif

/* tb_exe_stage.sv */
// Execute stage testbench
module tb_exe_stage;
    timeunit 1ns;
    timeprecision 1ps;
    import exe_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int N_ALU      = 200;
    localparam int N_MD       = 40;
    localparam int N_BP       = 20;
    localparam int N_OPS      = 17 + N_ALU + N_MD + 6 + 12 + N_BP * 10;
    localparam int WD_CYCLES  = N_OPS * (MD_CYCLES + 4) + 100;

    logic         clk;
    logic         rst_n;
    alu_op_t      e_alu_op_i;
    store_op_t    e_store_op_i;
    load_op_t     e_load_op_i;
    data_origin_t e_data_origin_i;
    data_target_t e_data_target_i;
    data_t        e_rs1_i;
    data_t        e_rs2_i;
    data_t        e_imm_i;
    data_t        e_pc4_i;
    data_t        e_brj_pc_i;
    reg_addr_t    e_waddr_i;
    logic         e_regfile_wr_i;
    logic         e_is_load_store_i;
    logic         e_data_wr_i;
    logic         e_data_rd_i;
    be_t          e_data_be_i;
    logic         stall_general_i;
    reg_addr_t    m_waddr_o;
    data_t        m_rd_o;
    data_t        m_data_addr_o;
    data_t        alu_o;
    logic         m_regfile_wr_o;
    logic         m_is_load_store_o;
    logic         m_data_wr_o;
    logic         m_data_rd_o;
    be_t          m_data_be_o;
    load_op_t     m_load_op_o;
    logic         d_alu_busy_o;

    // Expected memory-stage bundle
    reg_addr_t    exp_waddr;
    data_t        exp_rd;
    data_t        exp_addr;
    be_t          exp_be;
    load_op_t     exp_lop;
    logic [3:0]   exp_strb;

    int           n_errors;
    int           n_checks;
    int           n_tests;
    data_t        rng;

    `include "tb_exe_ref.svh"

    exe_stage i_exe_stage (.*);

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(WD_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", WD_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    function automatic data_t rand_word();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic check_data(input string what, input data_t got, input data_t exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input string what, input reg_addr_t got, input reg_addr_t exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_ctrl(input string what, input be_t got_be, input be_t exp_be,
                              input load_op_t got_lop, input load_op_t exp_lop,
                              input logic [3:0] got_strb, input logic [3:0] exp_strb);
        n_checks++;
        if (got_be !== exp_be || got_lop !== exp_lop || got_strb !== exp_strb)
        begin
            n_errors++;
            $display("[ERROR] %0t ns: %s be/load/strobes are %h/%h/%b, expected %h/%h/%b",
                     $time, what, got_be, got_lop, got_strb, exp_be, exp_lop, exp_strb);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_outputs(input string tag);
        check_addr({tag, " waddr"}, m_waddr_o, exp_waddr);
        check_data({tag, " rd"}, m_rd_o, exp_rd);
        check_data({tag, " data addr"}, m_data_addr_o, exp_addr);
        check_ctrl(tag, m_data_be_o, exp_be, m_load_op_o, exp_lop,
                   {m_regfile_wr_o, m_is_load_store_o, m_data_wr_o, m_data_rd_o}, exp_strb);
    endtask

    task automatic randomize_inputs();
        e_alu_op_i      = alu_op_t'(rand_word() % 11);  // Base operations only
        e_store_op_i    = store_op_t'(rand_word());
        e_load_op_i     = load_op_t'(rand_word());
        e_data_origin_i = data_origin_t'(rand_word());
        e_data_target_i = data_target_t'(rand_word());
        e_rs1_i         = rand_word();
        e_rs2_i         = rand_word();
        e_imm_i         = rand_word();
        e_pc4_i         = rand_word();
        e_brj_pc_i      = rand_word();
        e_waddr_i       = reg_addr_t'(rand_word());
        e_data_be_i     = be_t'(rand_word());
        {e_regfile_wr_i, e_is_load_store_i, e_data_wr_i, e_data_rd_i} = 4'(rand_word());
    endtask

    task automatic set_expected();
        data_t op2;
        op2 = e_data_origin_i[0] ? e_imm_i : e_rs2_i;
        if (e_alu_op_i[4])
            exp_addr = ref_muldiv(e_alu_op_i, e_rs1_i, op2);
        else
            exp_addr = ref_alu(e_alu_op_i, e_rs1_i, op2);
        exp_rd    = ref_writeback(e_data_target_i, e_data_origin_i, exp_addr,
                                  ref_store(e_store_op_i, e_rs2_i), e_pc4_i, e_brj_pc_i);
        exp_waddr = e_waddr_i;
        exp_be    = e_data_be_i;
        exp_lop   = e_load_op_i;
        exp_strb  = {e_regfile_wr_i, e_is_load_store_i, e_data_wr_i, e_data_rd_i};
    endtask

    // Present current inputs on one unstalled edge
    task automatic capture_check(input string tag);
        stall_general_i = 1'b0;
        set_expected();
        step();
        check_outputs(tag);
        check_data({tag, " alu"}, alu_o, exp_addr);  // Inputs still unchanged
    endtask

    task automatic run_muldiv(input alu_op_t op, input data_t a, input data_t b);
        int   n_busy;
        int   waited;
        logic prev;
        logic done;
        randomize_inputs();
        e_alu_op_i         = op;
        e_rs1_i            = a;
        e_rs2_i            = b;
        e_data_origin_i[0] = 1'b0;
        e_data_target_i    = 2'd0;
        stall_general_i    = 1'b1;  // Controller holds the stage while busy
        set_expected();
        n_busy = 0;
        waited = 0;
        prev   = 1'b0;
        done   = 1'b0;
        while (!done && waited < MD_CYCLES + 8)
        begin
            step();
            waited++;
            if (d_alu_busy_o)
                n_busy++;
            done = prev & ~d_alu_busy_o;
            prev = d_alu_busy_o;
        end
        if (!done)
        begin
            n_errors++;
            $display("Multiply/divide op %h never finished its busy phase", op);
        end
        else if (n_busy != MD_CYCLES || waited != MD_CYCLES + 1)
        begin
            n_errors++;
            $display("[ERROR] %0t ns: op %h busy %0d cycles in %0d edges, expected %0d in %0d",
                     $time, op, n_busy, waited, MD_CYCLES, MD_CYCLES + 1);
        end
        stall_general_i = 1'b0;  // Result valid in the done cycle
        step();
        check_outputs("muldiv");
        check_data("muldiv alu", alu_o, exp_addr);
        check_flag("busy after capture", d_alu_busy_o, 1'b0);
        e_alu_op_i = ALU_ADD;
    endtask

    task automatic report_test(input string name, input int err_before);
        n_tests++;
        $display("test %-18s %s, %0d errors", name,
                 (n_errors == err_before) ? "ok" : "bad", n_errors - err_before);
    endtask

    initial
    begin
        int err_before;
        int len;
        $timeformat(-9, 0, "", 0);
        n_errors = 0;
        n_checks = 0;
        n_tests  = 0;
        rng      = 32'hef11;
        rst_n    = 1'b0;
        stall_general_i = 1'b0;
        randomize_inputs();
        e_alu_op_i = ALU_ADD;
        repeat (16) step();
        rst_n = 1'b1;

        err_before = n_errors;
        exp_waddr  = '0;
        exp_rd     = '0;
        exp_addr   = '0;
        exp_be     = '0;
        exp_lop    = '0;
        exp_strb   = '0;
        check_outputs("reset");
        check_flag("busy after reset", d_alu_busy_o, 1'b0);
        report_test("reset state", err_before);

        err_before = n_errors;
        repeat (N_ALU)
        begin
            randomize_inputs();
            e_data_target_i = 2'd0;
            capture_check("alu");
        end
        report_test("base alu", err_before);

        err_before = n_errors;
        run_muldiv(DIV, rand_word(), 32'd0);
        run_muldiv(DIVU, rand_word(), 32'd0);
        run_muldiv(REM, rand_word(), 32'd0);
        run_muldiv(REMU, rand_word(), 32'd0);
        run_muldiv(DIV, 32'h8000_0000, 32'hffff_ffff);
        run_muldiv(REM, 32'h8000_0000, 32'hffff_ffff);
        repeat (N_MD)
            run_muldiv(alu_op_t'({2'b10, 3'(rand_word())}), rand_word(), rand_word());
        report_test("m extension", err_before);

        err_before = n_errors;
        for (int s = 0; s < 4; s++)
        begin
            for (int t = 1; t < 4; t++)
            begin
                randomize_inputs();
                e_store_op_i       = store_op_t'(s);
                e_data_target_i    = data_target_t'(t);
                e_data_origin_i[1] = s[0];  // Both link sources
                capture_check("writeback");
            end
        end
        report_test("store and writeback", err_before);

        err_before = n_errors;
        repeat (N_BP)
        begin
            randomize_inputs();
            capture_check("before stall");
            len = 1 + rand_word() % 8;
            repeat (len)
            begin
                randomize_inputs();
                stall_general_i = 1'b1;
                step();
                check_outputs("stalled");
            end
            capture_check("after stall");
        end
        report_test("back-pressure", err_before);

        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* src.f */
+incdir+.
exe_pkg.sv
muldiv_if.sv
int_alu.sv
muldiv_unit.sv
exe_stage.sv
tb_exe_stage.sv

/* Bender.yml */
package:
  name: exe_stage

sources:
  - exe_pkg.sv
  - muldiv_if.sv
  - int_alu.sv
  - muldiv_unit.sv
  - exe_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_exe_stage.sv
